// File: design/msg_config.svh
// Bus, target and payload width macros with the derived chunk count
`ifndef MSG_CONFIG_SVH
`define MSG_CONFIG_SVH

// Width of one flit data word
`define MSG_BUS_W 8

// Target address width
// Must fit in one flit
`define MSG_TARGET_W 8

// Full payload width
// Should be a whole multiple of the bus width
`define MSG_PAYLOAD_W 24

// Bus-wide payload chunks per message, one valid bit each
`define MSG_CHUNKS (`MSG_PAYLOAD_W / `MSG_BUS_W)

// Chunk index and chunk count are both two bits wide
// This covers up to three chunks

`endif

// File: design/msg_ctrl_pkg.sv
// Transmit phase and message opcode enums
`default_nettype none

`include "msg_config.svh"

package msg_ctrl_pkg;

    // Flit phases of the transmitter
    typedef enum logic [1:0] {
        // Target address flit
        MSG_PH_TARGET  = 2'd0,
        // Opcode flit
        MSG_PH_OPCODE  = 2'd1,
        // Payload chunk flits
        MSG_PH_PAYLOAD = 2'd2
    } msg_tx_phase_e;

    // Message opcodes, one flit wide
    // Passed through the link unchanged
    typedef enum logic [`MSG_BUS_W-1:0] {
        MSG_OP_NOP    = 8'h00,
        MSG_OP_WRITE  = 8'h01,
        MSG_OP_READ   = 8'h02,
        MSG_OP_LOAD   = 8'h03,
        MSG_OP_SIGNAL = 8'h04
    } msg_opcode_e;

endpackage

`default_nettype wire

// File: design/msg_bus_pkg.sv
// Flit, transmit request and received message struct types
`default_nettype none

`include "msg_config.svh"

package msg_bus_pkg;

    // One flit on the internal bus
    // Last marks the final flit of a message
    typedef struct packed {
        logic                  last;
        logic [`MSG_BUS_W-1:0] data;
    } msg_flit_t;

    // Message handed to the transmitter
    typedef struct packed {
        logic [`MSG_TARGET_W-1:0]  target;
        msg_ctrl_pkg::msg_opcode_e opcode;
        logic [`MSG_PAYLOAD_W-1:0] payload;
        // One bit per payload chunk, chunk 0 in bit 0
        logic [`MSG_CHUNKS-1:0]    valid;
    } msg_tx_req_t;

    // Message rebuilt by the receiver
    typedef struct packed {
        logic [`MSG_TARGET_W-1:0]  target;
        msg_ctrl_pkg::msg_opcode_e opcode;
        // Valid chunks packed low, upper chunks zero
        logic [`MSG_PAYLOAD_W-1:0] payload;
        // Number of chunks received
        logic [1:0]                count;
    } msg_rx_msg_t;

endpackage

`default_nettype wire

// File: design/msg_tx_fsm.sv
// Transmit phase FSM for target, opcode and payload flits
`timescale 1ns/1ps
`default_nettype none

module msg_tx_fsm (
      input  wire                         clk
    , input  wire                         arst_n
    // Flit bus can take a new flit
    , input  wire                         bus_ready
    // Request accepted this cycle
    , input  logic                        req_fire
    // Chunk being sent is the final one
    , input  logic                        chunk_last
    , output msg_ctrl_pkg::msg_tx_phase_e phase
    , output logic                        tx_ready
);

    msg_ctrl_pkg::msg_tx_phase_e phase_q;
    msg_ctrl_pkg::msg_tx_phase_e phase_d;

    // New requests only in TARGET with the bus free
    assign tx_ready = (phase_q == msg_ctrl_pkg::MSG_PH_TARGET) && bus_ready;
    assign phase    = phase_q;

    always_comb begin
        phase_d = phase_q;
        // Phase only moves when the flit register is updated
        if (bus_ready) begin
            case (phase_q)
                msg_ctrl_pkg::MSG_PH_TARGET: begin
                    if (req_fire) phase_d = msg_ctrl_pkg::MSG_PH_OPCODE;
                end
                // Opcode always one flit
                msg_ctrl_pkg::MSG_PH_OPCODE: begin
                    phase_d = msg_ctrl_pkg::MSG_PH_PAYLOAD;
                end
                msg_ctrl_pkg::MSG_PH_PAYLOAD: begin
                    if (chunk_last) phase_d = msg_ctrl_pkg::MSG_PH_TARGET;
                end
                // Unused encoding, back to idle
                default: begin
                    phase_d = msg_ctrl_pkg::MSG_PH_TARGET;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= msg_ctrl_pkg::MSG_PH_TARGET;
        end else begin
            phase_q <= phase_d;
        end
    end

endmodule

`default_nettype wire

// File: design/msg_chunk_counter.sv
// Remaining-chunk mask register with next index and last-chunk flag
`timescale 1ns/1ps
`default_nettype none

`include "msg_config.svh"

module msg_chunk_counter (
      input  wire                    clk
    , input  wire                    arst_n
    // Load a new mask on request accept
    , input  wire                    load
    , input  logic [`MSG_CHUNKS-1:0] load_mask
    // Drop the current chunk
    , input  wire                    advance
    , output logic [1:0]             chunk_idx
    , output logic                   chunk_last
);

    // Chunks still to send
    logic [`MSG_CHUNKS-1:0] mask_q;
    // Mask with its lowest set bit cleared
    logic [`MSG_CHUNKS-1:0] rest_mask;

    assign rest_mask  = mask_q & (mask_q - 1'b1);
    // Current chunk is the only one left
    assign chunk_last = (rest_mask == '0);

    // Index of the lowest set bit
    always_comb begin
        chunk_idx = 2'd0;
        // Scan downwards so the lowest hit wins
        for (int i = `MSG_CHUNKS - 1; i >= 0; i--) begin
            if (mask_q[i]) chunk_idx = 2'(i);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_q <= '0;
        end else if (load) begin
            mask_q <= load_mask;
        end else if (advance) begin
            mask_q <= rest_mask;
        end
    end

endmodule

`default_nettype wire

// File: design/msg_tx_datapath.sv
// Request capture and registered outgoing flit
`timescale 1ns/1ps
`default_nettype none

`include "msg_config.svh"

module msg_tx_datapath (
      input  wire                         clk
    , input  wire                         arst_n
    , input  msg_bus_pkg::msg_tx_req_t    tx_req
    , input  msg_ctrl_pkg::msg_tx_phase_e phase
    , input  wire                         bus_ready
    // Chunk selected by the counter
    , input  logic [1:0]                  chunk_idx
    , input  logic                        chunk_last
    , output logic                        req_fire
    , output msg_bus_pkg::msg_flit_t      bus_flit
    , output logic                        bus_valid
);

    // Held copy of the accepted request
    msg_ctrl_pkg::msg_opcode_e  opcode_q;
    logic [`MSG_PAYLOAD_W-1:0]  payload_q;

    // Accept needs TARGET, a free bus and at least one chunk
    assign req_fire = (phase == msg_ctrl_pkg::MSG_PH_TARGET) && bus_ready
                      && (|tx_req.valid);

    always_ff @(posedge clk) begin
        if (req_fire) begin
            opcode_q  <= tx_req.opcode;
            payload_q <= tx_req.payload;
        end
    end

    // Flit word, updated only once the previous flit has gone
    always_ff @(posedge clk) begin
        if (bus_ready) begin
            case (phase)
                // Target comes straight from the request port
                msg_ctrl_pkg::MSG_PH_TARGET: begin
                    bus_flit.data <= tx_req.target;
                    bus_flit.last <= 1'b0;
                end
                msg_ctrl_pkg::MSG_PH_OPCODE: begin
                    bus_flit.data <= opcode_q;
                    bus_flit.last <= 1'b0;
                end
                default: begin
                    bus_flit.data <= `MSG_BUS_W'(payload_q >> (chunk_idx * `MSG_BUS_W));
                    bus_flit.last <= chunk_last;
                end
            endcase
        end
    end

    // Flit valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_valid <= 1'b0;
        end else if (bus_ready) begin
            case (phase)
                msg_ctrl_pkg::MSG_PH_TARGET:  bus_valid <= req_fire;
                msg_ctrl_pkg::MSG_PH_OPCODE:  bus_valid <= 1'b1;
                msg_ctrl_pkg::MSG_PH_PAYLOAD: bus_valid <= 1'b1;
                default:                      bus_valid <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/msg_receiver.sv
// Flit deserializer that rebuilds a compacted message and holds it until taken
`timescale 1ns/1ps
`default_nettype none

`include "msg_config.svh"

module msg_receiver (
      input  wire                       clk
    , input  wire                       arst_n
    // Flit bus from the transmitter
    , input  msg_bus_pkg::msg_flit_t    bus_flit
    , input  wire                       bus_valid
    , output logic                      bus_ready
    // Finished message
    , output msg_bus_pkg::msg_rx_msg_t  rx_msg
    , output logic                      rx_valid
    , input  wire                       rx_ready
);

    // Flit positions within a message
    localparam logic [1:0] POS_TARGET  = 2'd0;
    localparam logic [1:0] POS_OPCODE  = 2'd1;
    localparam logic [1:0] POS_PAYLOAD = 2'd2;

    logic                                    xfer;
    logic [1:0]                              pos_q;
    logic [1:0]                              count_q;
    logic [`MSG_TARGET_W-1:0]                target_q;
    msg_ctrl_pkg::msg_opcode_e               opcode_q;
    logic [`MSG_CHUNKS-1:0][`MSG_BUS_W-1:0]  chunks_q;

    // Bus stalls while a finished message waits
    // This also keeps rx_msg steady until taken
    assign bus_ready = !rx_valid;
    assign xfer      = bus_valid && bus_ready;

    // Assembly registers double as the output
    always_comb begin
        rx_msg.target  = target_q;
        rx_msg.opcode  = opcode_q;
        rx_msg.payload = chunks_q;
        rx_msg.count   = count_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos_q    <= POS_TARGET;
            count_q  <= 2'd0;
            rx_valid <= 1'b0;
        end else begin
            if (xfer) begin
                // Restart on the last flit, else step and stay in payload
                if (bus_flit.last) begin
                    pos_q <= POS_TARGET;
                end else if (pos_q != POS_PAYLOAD) begin
                    pos_q <= pos_q + 2'd1;
                end
                // Fresh count for each message
                if (pos_q == POS_TARGET) begin
                    count_q <= 2'd0;
                end else if (pos_q == POS_PAYLOAD) begin
                    count_q <= count_q + 2'd1;
                end
            end
            // Publish on the last flit, release once taken
            if (xfer && bus_flit.last) begin
                rx_valid <= 1'b1;
            end else if (rx_ready) begin
                rx_valid <= 1'b0;
            end
        end
    end

    // Message fields
    always_ff @(posedge clk) begin
        if (xfer) begin
            case (pos_q)
                POS_TARGET: begin
                    target_q <= bus_flit.data;
                    // Unused chunk slots read as zero
                    chunks_q <= '0;
                end
                POS_OPCODE: begin
                    opcode_q <= msg_ctrl_pkg::msg_opcode_e'(bus_flit.data);
                end
                // Next free slot keeps the chunks packed low
                default: begin
                    chunks_q[count_q] <= bus_flit.data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/msg_link_top.sv
// Link top joining the transmit blocks and the receiver over the flit bus
`timescale 1ns/1ps
`default_nettype none

module msg_link_top (
      input  wire                       clk
    , input  wire                       arst_n
    // Message in
    , input  msg_bus_pkg::msg_tx_req_t  tx_req
    , output logic                      tx_ready
    // Message out
    , output msg_bus_pkg::msg_rx_msg_t  rx_msg
    , output logic                      rx_valid
    , input  wire                       rx_ready
);

    msg_ctrl_pkg::msg_tx_phase_e phase;
    logic                        req_fire;
    logic [1:0]                  chunk_idx;
    logic                        chunk_last;
    // Internal flit bus
    msg_bus_pkg::msg_flit_t      bus_flit;
    logic                        bus_valid;
    logic                        bus_ready;
    // Counter steps with each payload flit
    wire chunk_advance = bus_ready && (phase == msg_ctrl_pkg::MSG_PH_PAYLOAD);

    msg_tx_fsm fsm_i (
          .clk        (clk)
        , .arst_n     (arst_n)
        , .bus_ready  (bus_ready)
        , .req_fire   (req_fire)
        , .chunk_last (chunk_last)
        , .phase      (phase)
        , .tx_ready   (tx_ready)
    );

    msg_chunk_counter counter_i (
          .clk        (clk)
        , .arst_n     (arst_n)
        , .load       (req_fire)
        , .load_mask  (tx_req.valid)
        , .advance    (chunk_advance)
        , .chunk_idx  (chunk_idx)
        , .chunk_last (chunk_last)
    );

    msg_tx_datapath datapath_i (
          .clk        (clk)
        , .arst_n     (arst_n)
        , .tx_req     (tx_req)
        , .phase      (phase)
        , .bus_ready  (bus_ready)
        , .chunk_idx  (chunk_idx)
        , .chunk_last (chunk_last)
        , .req_fire   (req_fire)
        , .bus_flit   (bus_flit)
        , .bus_valid  (bus_valid)
    );

    msg_receiver receiver_i (
          .clk        (clk)
        , .arst_n     (arst_n)
        , .bus_flit   (bus_flit)
        , .bus_valid  (bus_valid)
        , .bus_ready  (bus_ready)
        , .rx_msg     (rx_msg)
        , .rx_valid   (rx_valid)
        , .rx_ready   (rx_ready)
    );

endmodule

`default_nettype wire

// File: tests/msg_link_tb.sv
// Message link testbench with stimulus table, LFSR back-pressure, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "msg_config.svh"

module msg_link_tb;

    localparam int NUM_TESTS      = 14;
    // Generous bound per table entry
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;

    // rx_ready modes
    localparam logic [1:0] RX_RND = 2'd0;
    localparam logic [1:0] RX_HI  = 2'd1;
    localparam logic [1:0] RX_LO  = 2'd2;

    // One table row
    typedef struct packed {
        msg_bus_pkg::msg_tx_req_t req;
        logic [1:0]               exp_count;
        logic [1:0]               rx_mode;
        // Wait for the receiver to empty before applying
        logic                     drain;
        // Previous message must still be waiting after this accept
        logic                     check_wait;
    } stim_entry_t;

    logic                     clk;
    logic                     arst_n;
    msg_bus_pkg::msg_tx_req_t tx_req;
    logic                     tx_ready;
    msg_bus_pkg::msg_rx_msg_t rx_msg;
    logic                     rx_valid;
    logic                     rx_ready;

    stim_entry_t              stim_table [NUM_TESTS];
    int                       fill_count;
    msg_bus_pkg::msg_rx_msg_t exp_q [$];
    int                       idx_q [$];
    logic [1:0]               rx_mode;
    // Mode as seen by the receive side and updated on rising edges
    logic [1:0]               rx_mode_seen;
    logic [31:0]              lfsr;
    logic                     held_valid;
    msg_bus_pkg::msg_rx_msg_t held_msg;
    int                       errors;
    int                       tests_done;
    int                       cycle_count;

    msg_link_top msg_link_top_i (
          .clk      (clk)
        , .arst_n   (arst_n)
        , .tx_req   (tx_req)
        , .tx_ready (tx_ready)
        , .rx_msg   (rx_msg)
        , .rx_valid (rx_valid)
        , .rx_ready (rx_ready)
    );

    always #4 clk = ~clk;

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // Valid chunks packed low in ascending order with the rest zero
    function automatic msg_bus_pkg::msg_rx_msg_t expected_msg(input stim_entry_t e);
        msg_bus_pkg::msg_rx_msg_t m;
        int                       slot;
        int                       c;
        m.target  = e.req.target;
        m.opcode  = e.req.opcode;
        m.payload = '0;
        m.count   = e.exp_count;
        slot      = 0;
        for (c = 0; c < `MSG_CHUNKS; c++) begin
            if (e.req.valid[c]) begin
                m.payload[slot*`MSG_BUS_W +: `MSG_BUS_W] =
                    e.req.payload[c*`MSG_BUS_W +: `MSG_BUS_W];
                slot++;
            end
        end
        return m;
    endfunction

    task automatic check_msg(input string name, input msg_bus_pkg::msg_rx_msg_t got,
                             input msg_bus_pkg::msg_rx_msg_t exp_msg);
        if (got !== exp_msg) begin
            errors++;
            $display("Mismatch %s: got %h_%h_%h_%h expected %h_%h_%h_%h", name,
                     got.target, got.opcode, got.payload, got.count,
                     exp_msg.target, exp_msg.opcode, exp_msg.payload, exp_msg.count);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp_bit);
        if (got !== exp_bit) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp_bit);
        end
    endtask

    // Flag bit 1 is drain and bit 0 is check_wait
    task automatic add_entry(input logic [`MSG_TARGET_W-1:0] target,
                             input msg_ctrl_pkg::msg_opcode_e opcode,
                             input logic [`MSG_PAYLOAD_W-1:0] payload,
                             input logic [`MSG_CHUNKS-1:0] mask, input logic [1:0] count,
                             input logic [1:0] mode, input logic [1:0] flags);
        stim_table[fill_count] = {target, opcode, payload, mask, count, mode, flags};
        fill_count++;
    endtask

    // Called on a falling edge and returns on the falling edge after the accept
    task automatic apply_entry(input int i);
        stim_entry_t e;
        e = stim_table[i];
        if (e.drain) begin
            while (exp_q.size() != 0) @(posedge clk);
            @(negedge clk);
        end
        rx_mode = e.rx_mode;
        tx_req  = e.req;
        if (|e.req.valid) begin
            exp_q.push_back(expected_msg(e));
            idx_q.push_back(i);
        end else begin
            tests_done++;
            $display("Test %0d: zero mask, no message expected", i);
        end
        while (!tx_ready) @(negedge clk);
        @(negedge clk);
        tx_req.valid = '0;
        if (e.check_wait) begin
            check_flag("rx_valid", rx_valid, 1'b1);
        end
    endtask

    always @(posedge clk) begin
        rx_mode_seen <= rx_mode;
    end

    // Receive side that drives rx_ready and checks taken messages
    always @(negedge clk) begin : rx_side
        msg_bus_pkg::msg_rx_msg_t exp_msg;
        int                       idx;
        int                       errs_before;
        // A message left waiting must hold still
        if (held_valid) begin
            check_flag("rx_valid", rx_valid, 1'b1);
            check_msg("rx_msg", rx_msg, held_msg);
        end
        case (rx_mode_seen)
            RX_RND: begin
                rx_ready = lfsr[0];
                lfsr     = next_lfsr(lfsr);
            end
            RX_HI:   rx_ready = 1'b1;
            default: rx_ready = 1'b0;
        endcase
        if (rx_valid && rx_ready) begin
            held_valid = 1'b0;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Receiver delivered a message that no table entry sent");
            end else begin
                exp_msg     = exp_q.pop_front();
                idx         = idx_q.pop_front();
                errs_before = errors;
                check_msg("rx_msg", rx_msg, exp_msg);
                tests_done++;
                $display("Test %0d: target %h, %0d chunks, %s", idx, exp_msg.target,
                         exp_msg.count, (errors == errs_before) ? "ok" : "wrong");
            end
        end else begin
            held_valid = rx_valid;
            held_msg   = rx_msg;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        tx_req      = '0;
        rx_ready    = 1'b0;
        rx_mode     = RX_LO;
        lfsr        = 32'h463e;
        held_valid  = 1'b0;
        held_msg    = '0;
        errors      = 0;
        tests_done  = 0;
        cycle_count = 0;
        fill_count  = 0;
        // Full mask, sparse masks and a zero mask with rx_ready high
        add_entry(8'h11, msg_ctrl_pkg::MSG_OP_WRITE,  24'hC3B2A1, 3'b111, 2'd3, RX_HI,  2'b00);
        add_entry(8'h22, msg_ctrl_pkg::MSG_OP_READ,   24'h665544, 3'b101, 2'd2, RX_HI,  2'b00);
        add_entry(8'h33, msg_ctrl_pkg::MSG_OP_LOAD,   24'h998877, 3'b010, 2'd1, RX_HI,  2'b00);
        add_entry(8'h44, msg_ctrl_pkg::MSG_OP_SIGNAL, 24'hFFEEDD, 3'b000, 2'd0, RX_HI,  2'b00);
        // Random back-pressure
        add_entry(8'h55, msg_ctrl_pkg::MSG_OP_NOP,    24'h123456, 3'b001, 2'd1, RX_RND, 2'b00);
        add_entry(8'h66, msg_ctrl_pkg::MSG_OP_WRITE,  24'hABCDEF, 3'b110, 2'd2, RX_RND, 2'b00);
        add_entry(8'h77, msg_ctrl_pkg::MSG_OP_READ,   24'h0F1E2D, 3'b011, 2'd2, RX_RND, 2'b00);
        add_entry(8'h88, msg_ctrl_pkg::MSG_OP_LOAD,   24'h55AA55, 3'b100, 2'd1, RX_RND, 2'b00);
        add_entry(8'h99, msg_ctrl_pkg::MSG_OP_SIGNAL, 24'h010203, 3'b000, 2'd0, RX_RND, 2'b00);
        add_entry(8'hA0, msg_ctrl_pkg::MSG_OP_WRITE,  24'h765432, 3'b111, 2'd3, RX_RND, 2'b00);
        // Two back to back with rx_ready low and then released
        add_entry(8'hB1, msg_ctrl_pkg::MSG_OP_READ,   24'h3C5A7E, 3'b111, 2'd3, RX_LO,  2'b10);
        add_entry(8'hC2, msg_ctrl_pkg::MSG_OP_LOAD,   24'h9A8B7C, 3'b011, 2'd2, RX_LO,  2'b01);
        add_entry(8'hD3, msg_ctrl_pkg::MSG_OP_SIGNAL, 24'hE1F2A3, 3'b100, 2'd1, RX_HI,  2'b00);
        add_entry(8'hE4, msg_ctrl_pkg::MSG_OP_NOP,    24'h4D5E6F, 3'b101, 2'd2, RX_RND, 2'b00);

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("tx_ready", tx_ready, 1'b1);
        check_flag("rx_valid", rx_valid, 1'b0);
        tests_done++;
        $display("Test reset: tx_ready high, rx_valid low, %s", (errors == 0) ? "ok" : "wrong");

        for (int i = 0; i < NUM_TESTS; i++) begin
            apply_entry(i);
        end

        // Drain and then stay idle to catch any extra message
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        rx_mode = RX_HI;
        repeat (20) @(negedge clk);
        check_flag("rx_valid", rx_valid, 1'b0);
        tests_done++;
        $display("Test idle: no further message after the table");

        $display("Done: %0d tests, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/msg_ctrl_pkg.sv
design/msg_bus_pkg.sv
design/msg_tx_fsm.sv
design/msg_chunk_counter.sv
design/msg_tx_datapath.sv
design/msg_receiver.sv
design/msg_link_top.sv
tests/msg_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= msg_link_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
